//--- verilog/mf2_settings.svh
////////////////////////////////////////////////////////////
// Multiface Two constants
// CPU bus widths, trap fetch addresses, snooped I/O ports
// and the shadow-store map inside the 8 KB MF2 RAM
////////////////////////////////////////////////////////////
`ifndef MF2_SETTINGS_SVH
`define MF2_SETTINGS_SVH

`define MF2_ADDR_W        16
`define MF2_DATA_W        8
`define MF2_RAM_AW        13

`define MF2_ENTRY_ADDR    16'h0066  // NMI vector fetch
`define MF2_HIDE_ADDR     16'h0065
`define MF2_PORT_PAGE     16'hFEE8  // Bit 1 high gives FEEA, page out

// I/O port high bytes that get snooped
`define MF2_IO_GA         8'h7F
`define MF2_IO_CRTC_SEL   8'hBC
`define MF2_IO_CRTC_DATA  8'hBD
`define MF2_IO_PPI        8'hF7
`define MF2_IO_UROM       8'hDF

// Top address bits of the ROM and RAM windows
`define MF2_ROM_BANK      3'b000
`define MF2_RAM_BANK      3'b001

// Shadow-store locations
`define MF2_ST_PEN_IDX    13'h1FCF
`define MF2_ST_PEN_BASE   13'h1F90  // Plus pen number
`define MF2_ST_BORDER     13'h1FDF
`define MF2_ST_MODE       13'h1FEF
`define MF2_ST_BANK       13'h1FFF
`define MF2_ST_CRTC_SEL   13'h1CFF
`define MF2_ST_CRTC_BASE  13'h1DB0  // Plus CRTC register number
`define MF2_ST_PPI        13'h17FF
`define MF2_ST_UROM       13'h1AAC

`endif

//--- verilog/mf2_pkg.sv
////////////////////////////////////////////////////////////
// Multiface Two types
// Bus vectors, mode setting and control FSM states
////////////////////////////////////////////////////////////
`include "mf2_settings.svh"

package mf2_pkg;

	typedef logic [`MF2_ADDR_W-1:0] cpu_addr_t;
	typedef logic [`MF2_DATA_W-1:0] cpu_data_t;
	typedef logic [`MF2_RAM_AW-1:0] shadow_addr_t;

	// 00 enabled, 01 hidden, 1x disabled
	typedef logic [1:0] mf2_mode_t;

	typedef enum logic [2:0] {
		state_idle,
		state_hidden,        // Page-in port ignored
		state_armed,         // NMI pending
		state_paged,
		state_paged_hidden   // Paged, drops to hidden on page out
	} mf2_state_t;

endpackage

//--- verilog/mf2_bus_decode.sv
////////////////////////////////////////////////////////////
// MF2 bus decode
// I/O write edge, page port match, pen and CRTC register
// tracking, shadow-store address lookup
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_settings.svh"

module mf2_bus_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  mf2_pkg::cpu_addr_t    cpu_addr,
	input  mf2_pkg::cpu_data_t    cpu_dout,
	input  logic                  io_wr,
	output logic                  io_wr_edge,
	output logic                  page_port_hit,
	output logic                  page_out,
	output logic                  store_strobe,
	output mf2_pkg::shadow_addr_t store_addr
);
	import mf2_pkg::*;

	localparam cpu_addr_t    page_port = `MF2_PORT_PAGE;
	localparam shadow_addr_t pen_base  = `MF2_ST_PEN_BASE;
	localparam shadow_addr_t crtc_base = `MF2_ST_CRTC_BASE;

	logic       io_wr_q;
	logic       port_match;
	logic [4:0] pen_idx;    // Bit 4 set means border
	logic [3:0] crtc_reg;

	assign io_wr_edge    = io_wr & ~io_wr_q;
	assign port_match    = (cpu_addr[15:2] == page_port[15:2]);   // FEE8 and FEEA
	assign page_port_hit = io_wr_edge & port_match;
	assign page_out      = cpu_addr[1];
	assign store_strobe  = io_wr_edge & ~port_match & (store_addr != '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			pen_idx  <= '0;
			crtc_reg <= '0;
		end else begin
			io_wr_q <= io_wr;
			// Gate array pen select carries the pen in the low bits
			if (io_wr_edge && cpu_addr[15:8] == `MF2_IO_GA && cpu_dout[7:6] == 2'b00)
				pen_idx <= cpu_dout[4:0];
			if (io_wr_edge && cpu_addr[15:8] == `MF2_IO_CRTC_SEL)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Shadow-store map
	////////////////////////////////////////////////////////////
	always_comb begin
		store_addr = '0;   // Not a snooped port
		case (cpu_addr[15:8])
			`MF2_IO_GA: begin
				case (cpu_dout[7:6])
					2'b00: store_addr = `MF2_ST_PEN_IDX;
					2'b01: store_addr = pen_idx[4] ? `MF2_ST_BORDER
						: {pen_base[12:4], pen_idx[3:0]};
					2'b10: store_addr = `MF2_ST_MODE;       // Mode and ROM enables
					default: store_addr = `MF2_ST_BANK;
				endcase
			end
			`MF2_IO_CRTC_SEL:  store_addr = `MF2_ST_CRTC_SEL;
			`MF2_IO_CRTC_DATA: store_addr = {crtc_base[12:4], crtc_reg};
			`MF2_IO_PPI:       store_addr = `MF2_ST_PPI;   // 8255 control
			`MF2_IO_UROM:      store_addr = `MF2_ST_UROM;
			default:           store_addr = '0;
		endcase
	end

endmodule

//--- verilog/mf2_control.sv
////////////////////////////////////////////////////////////
// MF2 paging control
// Button and M1 edge detect, NMI request, page FSM
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_settings.svh"

module mf2_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_t mf2_mode,
	input  logic               nmi_button,
	input  logic               m1,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	input  logic               io_wr_edge,
	input  logic               page_port_hit,
	input  logic               page_out,
	output logic               nmi,
	output logic               paged
);
	import mf2_pkg::*;

	mf2_state_t state;
	mf2_state_t state_next;
	logic       disabled;    // Mode bit 1 held from reset
	logic       m1_q;
	logic       button_q;
	logic       m1_rise;
	logic       button_rise;
	logic       entry_fetch;
	logic       hide_fetch;
	logic       port_wr;

	assign m1_rise     = m1 & ~m1_q;
	assign button_rise = nmi_button & ~button_q;
	assign entry_fetch = m1_rise && (cpu_addr == `MF2_ENTRY_ADDR);
	assign hide_fetch  = m1_rise && (cpu_addr == `MF2_HIDE_ADDR);
	assign port_wr     = io_wr_edge & page_port_hit;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q     <= 1'b0;
			button_q <= 1'b0;
			disabled <= mf2_mode[1];
			state    <= (mf2_mode == 2'b00) ? state_idle : state_hidden;
		end else begin
			m1_q     <= m1;
			button_q <= nmi_button;
			state    <= state_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			state_idle: begin
				if (button_rise && !disabled)
					state_next = state_armed;
				else if (port_wr && !page_out && !disabled)
					state_next = state_paged;   // Software page in
			end
			state_hidden: begin
				if (button_rise && !disabled)
					state_next = state_armed;
			end
			state_armed: begin
				if (entry_fetch)
					state_next = state_paged;
			end
			state_paged: begin
				if (port_wr && page_out)
					state_next = state_idle;
				else if (hide_fetch)
					state_next = state_paged_hidden;
			end
			state_paged_hidden: begin
				if (port_wr && page_out)
					state_next = state_hidden;
			end
			default: state_next = state_idle;
		endcase
	end

	assign nmi   = (state == state_armed);
	assign paged = (state == state_paged) || (state == state_paged_hidden);

endmodule

//--- verilog/mf2_shadow_ram.sv
////////////////////////////////////////////////////////////
// MF2 shadow RAM
// ROM and RAM window selects, port arbitration,
// 8 KB RAM with registered read, CPU read data
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_settings.svh"

module mf2_shadow_ram (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  paged,
	input  mf2_pkg::cpu_addr_t    cpu_addr,
	input  mf2_pkg::cpu_data_t    cpu_dout,
	input  logic                  mem_rd,
	input  logic                  mem_wr,
	input  logic                  store_strobe,
	input  mf2_pkg::shadow_addr_t store_addr,
	output logic                  ram_sel,
	output logic                  rom_sel,
	output mf2_pkg::cpu_data_t    rd_data
);
	import mf2_pkg::*;

	localparam int ram_depth = 1 << `MF2_RAM_AW;

	cpu_data_t    ram [ram_depth];
	shadow_addr_t ram_a;
	cpu_data_t    ram_din;
	cpu_data_t    ram_q;
	logic         ram_we;

	assign ram_sel = paged && (cpu_addr[`MF2_ADDR_W-1:`MF2_RAM_AW] == `MF2_RAM_BANK);
	assign rom_sel = paged && (cpu_addr[`MF2_ADDR_W-1:`MF2_RAM_AW] == `MF2_ROM_BANK);

	////////////////////////////////////////////////////////////
	// Port request, store wins over CPU write
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_strobe | (mem_wr & ram_sel);
	end

	always_ff @(posedge clk_sys) begin
		ram_din <= cpu_dout;
		if (store_strobe)
			ram_a <= store_addr;
		else
			ram_a <= cpu_addr[`MF2_RAM_AW-1:0];   // CPU write or read
	end

	// Write data shows on the read port in the same cycle
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_din;
			ram_q      <= ram_din;
		end else begin
			ram_q <= ram[ram_a];
		end
	end

	assign rd_data = (ram_sel && mem_rd) ? ram_q : '1;   // Idle bus reads FF

endmodule

//--- verilog/multiface_top.sv
////////////////////////////////////////////////////////////
// Multiface Two top level
// Bus decode, paging control and shadow RAM
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module multiface_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::cpu_addr_t cpu_addr,
	input  mf2_pkg::cpu_data_t cpu_dout,
	input  logic               io_wr,
	input  logic               mem_rd,
	input  logic               mem_wr,
	input  logic               m1,
	input  logic               nmi_button,
	input  mf2_pkg::mf2_mode_t mf2_mode,
	output logic               nmi,
	output logic               rom_sel,
	output logic               ram_sel,
	output mf2_pkg::cpu_data_t rd_data
);
	import mf2_pkg::*;

	logic         io_wr_edge;
	logic         page_port_hit;
	logic         page_out;
	logic         store_strobe;
	shadow_addr_t store_addr;
	logic         paged;

	mf2_bus_decode u_decode (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.io_wr         (io_wr),
		.io_wr_edge    (io_wr_edge),
		.page_port_hit (page_port_hit),
		.page_out      (page_out),
		.store_strobe  (store_strobe),
		.store_addr    (store_addr)
	);

	mf2_control u_control (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mf2_mode      (mf2_mode),
		.nmi_button    (nmi_button),
		.m1            (m1),
		.cpu_addr      (cpu_addr),
		.io_wr_edge    (io_wr_edge),
		.page_port_hit (page_port_hit),
		.page_out      (page_out),
		.nmi           (nmi),
		.paged         (paged)
	);

	mf2_shadow_ram u_shadow (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.paged         (paged),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.store_strobe  (store_strobe),
		.store_addr    (store_addr),
		.ram_sel       (ram_sel),
		.rom_sel       (rom_sel),
		.rd_data       (rd_data)
	);

endmodule

//--- tb/multiface_chk.sv
////////////////////////////////////////////////////////////
// MF2 bus checks
// Concurrent assertions bound to the top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module multiface_chk (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               nmi,
	input  logic               paged,
	input  logic               rom_sel,
	input  logic               ram_sel,
	input  logic               mem_rd,
	input  mf2_pkg::cpu_data_t rd_data
);

	// NMI is only requested from an unpaged state
	nmi_not_paged: assert property (@(posedge clk_sys) disable iff (reset) !(nmi && paged))
		else $error("nmi and paged are high together");

	sel_exclusive: assert property (@(posedge clk_sys) disable iff (reset) !(rom_sel && ram_sel))
		else $error("rom_sel and ram_sel are high together");

	idle_read_ff: assert property (@(posedge clk_sys) disable iff (reset)
		!mem_rd |-> rd_data == 8'hFF)
		else $error("rd_data is not FF while mem_rd is low");

endmodule

bind multiface_top multiface_chk u_chk (
	.clk_sys (clk_sys),
	.reset   (reset),
	.nmi     (nmi),
	.paged   (paged),
	.rom_sel (rom_sel),
	.ram_sel (ram_sel),
	.mem_rd  (mem_rd),
	.rd_data (rd_data)
);

//--- tb/tb_multiface.sv
////////////////////////////////////////////////////////////
// Multiface Two testbench
// Clock, reset, bus stimulus, reference model,
// output compare, watchdog and summary
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_multiface;

	localparam int budget_cycles = 1000;   // All tests with margin, 4 us

	logic        clk_sys;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;
	logic        m1;
	logic        nmi_button;
	logic [1:0]  mf2_mode;
	logic        nmi;
	logic        rom_sel;
	logic        ram_sel;
	logic [7:0]  rd_data;

	// Reference model
	logic        exp_nmi;
	logic        exp_paged;
	logic        ref_hidden;   // Page out returns to hidden
	logic [1:0]  ref_mode;
	logic [4:0]  ref_pen;
	logic [3:0]  ref_crtc;
	logic [7:0]  ref_ram [0:8191];
	logic [12:0] stored_q [$];
	logic [7:0]  exp_rd;
	logic        exp_rom;
	logic        exp_ram;
	logic        rd_check;
	logic        check_en;
	int          err_count;
	int          test_errs;
	int          check_count;
	int          test_num;
	integer      seed;

	multiface_top UUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.io_wr      (io_wr),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.m1         (m1),
		.nmi_button (nmi_button),
		.mf2_mode   (mf2_mode),
		.nmi        (nmi),
		.rom_sel    (rom_sel),
		.ram_sel    (ram_sel),
		.rd_data    (rd_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Shadow address of a snooped I/O write, zero when not snooped
	function automatic logic [12:0] mf2_ref_store_addr(input logic [15:0] addr,
			input logic [7:0] data, input logic [4:0] pen, input logic [3:0] crtc);
		logic [12:0] a;
		a = 13'h0000;
		case (addr[15:8])
			8'h7F: begin
				case (data[7:6])
					2'b00: a = 13'h1FCF;
					2'b01: a = pen[4] ? 13'h1FDF : 13'h1F90 + {9'd0, pen[3:0]};
					2'b10: a = 13'h1FEF;
					default: a = 13'h1FFF;
				endcase
			end
			8'hBC: a = 13'h1CFF;
			8'hBD: a = 13'h1DB0 + {9'd0, crtc};
			8'hF7: a = 13'h17FF;
			8'hDF: a = 13'h1AAC;
			default: a = 13'h0000;
		endcase
		return a;
	endfunction

	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] expv,
			input logic [7:0] actv);
		$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
		err_count = err_count + 1;
		test_errs = test_errs + 1;
	endtask

	task automatic finish_test(input string name);
		test_num = test_num + 1;
		$display("Test %0d %s: %0d errors", test_num, name, test_errs);
		test_errs = 0;
	endtask

	task automatic apply_reset(input logic [1:0] mode);
		check_en = 1'b0;
		mf2_mode = mode;
		reset    = 1'b1;
		repeat (8) step_cycle();
		reset      = 1'b0;
		ref_mode   = mode;
		exp_nmi    = 1'b0;
		exp_paged  = 1'b0;
		ref_hidden = (mode != 2'b00);
		check_en   = 1'b1;
	endtask

	task automatic probe(input logic [15:0] addr);
		cpu_addr = addr;   // Selects checked by the compare process
		step_cycle();
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		logic [12:0] st;
		st = mf2_ref_store_addr(addr, data, ref_pen, ref_crtc);
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		step_cycle();
		if (addr == 16'hFEEA || addr == 16'hFEE8) begin
			if (addr[1] && exp_paged)
				exp_paged = 1'b0;
			else if (!addr[1] && !exp_paged && !exp_nmi && !ref_hidden && !ref_mode[1])
				exp_paged = 1'b1;
		end else if (st != 13'h0000) begin
			ref_ram[st] = data;
			stored_q.push_back(st);
		end
		if (addr[15:8] == 8'h7F && data[7:6] == 2'b00)
			ref_pen = data[4:0];
		if (addr[15:8] == 8'hBC)
			ref_crtc = data[3:0];
		io_wr = 1'b0;
		step_cycle();   // Low again before the next edge
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		if (exp_paged && addr[15:13] == 3'b001)
			ref_ram[addr[12:0]] = data;
		step_cycle();
		mem_wr = 1'b0;
	endtask

	task automatic mem_read(input logic [15:0] addr);
		cpu_addr = addr;
		mem_rd   = 1'b1;
		rd_check = 1'b0;   // Read latency
		step_cycle();
		step_cycle();
		if (exp_paged && addr[15:13] == 3'b001)
			exp_rd = ref_ram[addr[12:0]];
		else
			exp_rd = 8'hFF;
		rd_check = 1'b1;
		step_cycle();
		mem_rd = 1'b0;
		exp_rd = 8'hFF;
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		cpu_addr = addr;
		m1       = 1'b1;
		step_cycle();
		if (addr == 16'h0066 && exp_nmi) begin
			exp_nmi    = 1'b0;
			exp_paged  = 1'b1;
			ref_hidden = 1'b0;
		end else if (addr == 16'h0065 && exp_paged) begin
			ref_hidden = 1'b1;
		end
		m1 = 1'b0;
		step_cycle();
	endtask

	task automatic button_press();
		nmi_button = 1'b1;
		step_cycle();
		if (!exp_paged && !exp_nmi && !ref_mode[1])
			exp_nmi = 1'b1;
		nmi_button = 1'b0;
		step_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// Compare, half a cycle away from the input changes
	////////////////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (check_en) begin
			exp_rom = exp_paged && (cpu_addr[15:13] == 3'b000);
			exp_ram = exp_paged && (cpu_addr[15:13] == 3'b001);
			check_count = check_count + 1;
			assert (nmi === exp_nmi)
				else report_mismatch("nmi", {7'd0, exp_nmi}, {7'd0, nmi});
			assert (rom_sel === exp_rom)
				else report_mismatch("rom_sel", {7'd0, exp_rom}, {7'd0, rom_sel});
			assert (ram_sel === exp_ram)
				else report_mismatch("ram_sel", {7'd0, exp_ram}, {7'd0, ram_sel});
			if (rd_check)
				assert (rd_data === exp_rd) else report_mismatch("rd_data", exp_rd, rd_data);
		end
	end

	initial begin
		#(budget_cycles * 4);
		$display("Watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		logic [12:0] st;
		reset = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		io_wr = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		m1 = 1'b0;
		nmi_button = 1'b0;
		mf2_mode = 2'b00;
		ref_pen = 5'd0;
		ref_crtc = 4'd0;
		exp_rd = 8'hFF;
		rd_check = 1'b1;
		check_en = 1'b0;
		err_count = 0;
		test_errs = 0;
		check_count = 0;
		test_num = 0;
		seed = 32'h2d67;

		apply_reset(2'b00);
		probe(16'h0000);
		mem_read(16'h2000);
		finish_test("reset state");

		button_press();
		m1_fetch(16'h0066);   // NMI entry pages in
		probe(16'h0000);
		probe(16'h1FFF);
		probe(16'h2000);
		probe(16'h3FFF);
		probe(16'h4000);
		finish_test("nmi entry and selects");

		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			a = {3'b001, r[12:0]};
			mem_write(a, r[23:16]);
			mem_read(a);
		end
		finish_test("random RAM data");

		////////////////////////////////////////////////////////////
		// Shadow stores while paged out
		////////////////////////////////////////////////////////////
		io_write(16'hFEEA, 8'h00);
		stored_q.delete();
		r = $random(seed);
		io_write(16'h7F00, 8'h03);               // Pen 3
		io_write(16'h7F00, {2'b01, r[5:0]});
		io_write(16'h7F00, 8'h10);               // Border
		io_write(16'h7F00, {2'b01, r[13:8]});
		io_write(16'h7F00, {2'b10, r[21:16]});
		io_write(16'h7F00, {2'b11, r[29:24]});
		io_write(16'hBC00, 8'h0C);
		io_write(16'hBD00, r[7:0]);
		io_write(16'hF700, 8'h82);
		io_write(16'hDF00, r[15:8]);
		io_write(16'hFEE8, 8'h00);
		while (stored_q.size() > 0) begin
			st = stored_q.pop_front();
			mem_read(16'h2000 + {3'b000, st});
		end
		finish_test("shadow stores");

		m1_fetch(16'h0065);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);   // Ignored once hidden
		probe(16'h2000);
		button_press();
		m1_fetch(16'h0066);
		finish_test("hidden mode");

		apply_reset(2'b10);
		button_press();
		io_write(16'hFEE8, 8'h00);
		probe(16'h2000);
		finish_test("disabled mode");

		$display("Tests %0d, checks %0d, errors %0d", test_num, check_count, err_count);
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verilog
verilog/mf2_pkg.sv
verilog/mf2_bus_decode.sv
verilog/mf2_control.sv
verilog/mf2_shadow_ram.sv
verilog/multiface_top.sv
tb/multiface_chk.sv
tb/tb_multiface.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Multiface Two testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_multiface \
	-f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_multiface)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1
